// File: ntt_mem_subsys.f
+incdir+logic
logic/ntt_types_pkg.sv
logic/ahb_bus_pkg.sv
logic/ntt_ahb_mem_adapter.sv
logic/ntt_ctrl_regs.sv
logic/ntt_coeff_mem.sv
logic/ntt_mem_subsys.sv
bench/ntt_mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NTT memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f ntt_mem_subsys.f \
    --top-module ntt_mem_subsys_tb \
    -Mdir obj_dir -o ntt_mem_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/ntt_mem_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit "$status"
fi
exit 0

// File: bench/ntt_mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "ntt_mem_cfg.svh"

module ntt_mem_subsys_tb
    import ntt_types_pkg::*;
    import ahb_bus_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ENG_WR = 8;    // Random engine word writes
    localparam int NUM_CTRL   = 16;   // Random control writes
    // Cycle budget of all tests, reset included
    localparam int TEST_CYCLES = 3 + `MEM_WORDS * `LANES * 3 + (`MEM_WORDS + 1)
                               + NUM_ENG_WR * 10 + NUM_CTRL * 2 + 8
                               + 12 + (`MEM_WORDS + 1);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 1000) * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n_i;
    ahb_req_t               ahb_req;
    ahb_rsp_t               ahb_rsp;
    ntt_port_req_t          eng_req;
    ntt_word_t              ntt_rd_data;
    ntt_ctrl_t              ntt_ctrl;
    logic                   ntt_en;

    ntt_word_t              shadow [`MEM_WORDS];   // 256 coeffs, word by lane
    logic [31:0]            rng_state;
    logic [`AHB_DATA_W-1:0] rd_data;               // Last host read result

    ntt_mem_subsys UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ahb_req_i     (ahb_req),
        .ahb_rsp_o     (ahb_rsp),
        .eng_req_i     (eng_req),
        .ntt_rd_data_o (ntt_rd_data),
        .ntt_ctrl_o    (ntt_ctrl),
        .ntt_en_o      (ntt_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    // ====================
    // Random numbers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic fail_value(input string name, input logic [`WORD_W-1:0] exp_v,
                              input logic [`WORD_W-1:0] got_v);
        $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, exp_v, got_v);
        $display("Simulation failed");
        $fatal(1, "Value mismatch");
    endtask

    task automatic check_coeff(input string name, input coeff_t got, input coeff_t exp_v);
        if (got !== exp_v) fail_value(name, `WORD_W'(exp_v), `WORD_W'(got));
    endtask

    task automatic check_word(input string name, input ntt_word_t got, input ntt_word_t exp_v);
        if (got !== exp_v) fail_value(name, exp_v, got);
    endtask

    task automatic check_ctrl(input string name, input ntt_ctrl_t got, input ntt_ctrl_t exp_v);
        if (got !== exp_v) fail_value(name, `WORD_W'(exp_v), `WORD_W'(got));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_v);
        if (got !== exp_v) fail_value(name, `WORD_W'(exp_v), `WORD_W'(got));
    endtask

    task automatic check_data(input string name, input logic [`AHB_DATA_W-1:0] got,
                              input logic [`AHB_DATA_W-1:0] exp_v);
        if (got !== exp_v) fail_value(name, `WORD_W'(exp_v), `WORD_W'(got));
    endtask

    // ====================
    // Bus drivers
    // ====================
    // One transfer, hold and err sampled mid-cycle
    task automatic host_issue(input logic wr, input logic [`AHB_ADDR_W-1:0] addr,
                              input logic [`AHB_DATA_W-1:0] data, input logic exp_err);
        @(posedge clk);
        ahb_req.dv    <= 1'b1;
        ahb_req.write <= wr;
        ahb_req.addr  <= addr;
        ahb_req.wdata <= data;
        @(negedge clk);
        check_bit("ahb_rsp.hold", ahb_rsp.hold, 1'b0);
        check_bit("ahb_rsp.err", ahb_rsp.err, exp_err);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        ahb_req <= '0;   // Previous transfer taken at this edge
    endtask

    task automatic host_read(input logic [`AHB_ADDR_W-1:0] addr, input logic exp_err);
        host_issue(1'b0, addr, '0, exp_err);
        bus_idle();
        @(negedge clk);
        rd_data = ahb_rsp.rdata;   // Valid one cycle after acceptance
    endtask

    task automatic engine_write(input logic [`WORD_ADDR_W-1:0] word, input ntt_word_t data);
        @(posedge clk);
        eng_req.wr_en   <= 1'b1;
        eng_req.wr_addr <= word;
        eng_req.wr_data <= data;
        @(posedge clk);
        eng_req.wr_en   <= 1'b0;
        shadow[word] = data;
    endtask

    // Back-to-back reads, each checked one cycle later
    task automatic engine_read_all();
        for (int w = 0; w <= `MEM_WORDS; w++) begin
            @(posedge clk);
            eng_req.rd_en   <= (w < `MEM_WORDS);
            eng_req.rd_addr <= `WORD_ADDR_W'(w);
            @(negedge clk);
            if (w > 0) check_word("ntt_rd_data", ntt_rd_data, shadow[`WORD_ADDR_W'(w - 1)]);
        end
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_host_coeffs();
        logic [`AHB_ADDR_W-1:0] addr;
        logic [31:0]            data;
        for (int i = 0; i < `MEM_WORDS * `LANES; i++) begin
            addr = `AHB_ADDR_W'(i);
            data = next_random();
            host_issue(1'b1, addr, data, 1'b0);
            shadow[addr[7:2]][addr[1:0]] = data[`COEFF_W-1:0];
            host_read(addr, 1'b0);   // Issued right behind the write
            check_coeff("ahb_rsp.rdata", rd_data[`COEFF_W-1:0], data[`COEFF_W-1:0]);
        end
    endtask

    task automatic test_engine_write();
        logic [31:0] r;
        ntt_word_t   data;
        logic [2:0]  lane;
        for (int k = 0; k < NUM_ENG_WR; k++) begin
            r    = next_random();
            data = {next_random(), next_random(), next_random()};
            engine_write(r[5:0], data);
            for (lane = 3'd0; lane < 3'd4; lane++) begin
                host_read({1'b0, r[5:0], lane[1:0]}, 1'b0);
                check_data("ahb_rsp.rdata", rd_data, `AHB_DATA_W'(data[lane[1:0]]));
            end
        end
    endtask

    task automatic test_ctrl_enable();
        logic [31:0] r;
        logic [8:0]  v;
        ntt_ctrl_t   exp_c;
        v = '0;
        for (int k = 0; k < NUM_CTRL; k++) begin
            r = next_random();
            v = r[8:0];
            host_issue(1'b1, `AHB_ADDR_W'(`CTRL_ADDR), `AHB_DATA_W'(v), 1'b0);
            bus_idle();
            @(negedge clk);
            exp_c.mode          = mode_t'(v[2:0]);
            exp_c.accumulate    = v[3];
            exp_c.sampler_valid = v[4];
            exp_c.masking_en    = v[5];
            exp_c.shuffle_en    = v[6];
            exp_c.zeroize       = v[7];
            exp_c.sampler_mode  = v[8];
            check_bit("ntt_ctrl.accumulate", ntt_ctrl.accumulate, v[3]);
            check_bit("ntt_ctrl.sampler_valid", ntt_ctrl.sampler_valid, v[4]);
            check_bit("ntt_ctrl.masking_en", ntt_ctrl.masking_en, v[5]);
            check_bit("ntt_ctrl.shuffle_en", ntt_ctrl.shuffle_en, v[6]);
            check_bit("ntt_ctrl.zeroize", ntt_ctrl.zeroize, v[7]);
            check_bit("ntt_ctrl.sampler_mode", ntt_ctrl.sampler_mode, v[8]);
            check_ctrl("ntt_ctrl", ntt_ctrl, exp_c);   // Mode included
        end
        host_read(`AHB_ADDR_W'(`CTRL_ADDR), 1'b0);
        check_data("ahb_rsp.rdata", rd_data, `AHB_DATA_W'(v));
        host_read(`AHB_ADDR_W'(`EN_ADDR), 1'b0);
        check_data("ahb_rsp.rdata", rd_data, '0);
        host_issue(1'b1, `AHB_ADDR_W'(`EN_ADDR), 32'h1, 1'b0);
        check_bit("ntt_en", ntt_en, 1'b0);   // Not before the edge
        bus_idle();
        @(negedge clk);
        check_bit("ntt_en", ntt_en, 1'b1);
        @(negedge clk);
        check_bit("ntt_en", ntt_en, 1'b0);
    endtask

    task automatic test_hold_err();
        logic [31:0]            r;
        logic [`AHB_ADDR_W-1:0] addr;
        ntt_word_t              data;
        ntt_ctrl_t              ctrl_before;
        logic [2:0]             lane;
        r    = next_random();
        addr = {1'b0, r[7:0]};
        data = {next_random(), next_random(), next_random()};
        // Host and engine hit the same word together
        @(posedge clk);
        ahb_req.dv      <= 1'b1;
        ahb_req.write   <= 1'b1;
        ahb_req.addr    <= addr;
        ahb_req.wdata   <= ~r;
        eng_req.wr_en   <= 1'b1;
        eng_req.wr_addr <= addr[7:2];
        eng_req.wr_data <= data;
        @(negedge clk);
        check_bit("ahb_rsp.hold", ahb_rsp.hold, 1'b1);
        check_bit("ahb_rsp.err", ahb_rsp.err, 1'b0);
        @(posedge clk);
        ahb_req       <= '0;
        eng_req.wr_en <= 1'b0;
        shadow[addr[7:2]] = data;   // Engine wins
        for (lane = 3'd0; lane < 3'd4; lane++) begin
            host_read({addr[8:2], lane[1:0]}, 1'b0);
            check_data("ahb_rsp.rdata", rd_data, `AHB_DATA_W'(data[lane[1:0]]));
        end
        // Out of range, dropped
        ctrl_before = ntt_ctrl;
        host_issue(1'b1, 9'd258, next_random(), 1'b1);
        host_read(9'd511, 1'b1);
        check_ctrl("ntt_ctrl", ntt_ctrl, ctrl_before);
        engine_read_all();   // Memory still matches shadow
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk       = 1'b0;
        rng_state = 32'd79;
        rst_n_i   <= 1'b0;
        ahb_req   <= '0;
        eng_req   <= '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("ntt_en", ntt_en, 1'b0);
        check_bit("ahb_rsp.hold", ahb_rsp.hold, 1'b0);
        check_bit("ahb_rsp.err", ahb_rsp.err, 1'b0);
        check_ctrl("ntt_ctrl", ntt_ctrl, '0);
        check_data("ahb_rsp.rdata", ahb_rsp.rdata, '0);

        test_host_coeffs();
        engine_read_all();    // Engine view of host data
        test_engine_write();
        test_ctrl_enable();
        test_hold_err();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/ntt_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "ntt_mem_cfg.svh"

module ntt_mem_subsys
    import ntt_types_pkg::*;
    import ahb_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire ahb_req_t       ahb_req_i,
    output ahb_rsp_t            ahb_rsp_o,
    input  wire ntt_port_req_t  eng_req_i,
    output ntt_word_t           ntt_rd_data_o,
    output ntt_ctrl_t           ntt_ctrl_o,
    output logic                ntt_en_o
);

    // ====================
    // Adapter to memory
    // ====================
    logic                         mem_ena, mem_wea;
    logic [`WORD_ADDR_W-1:0]      mem_word;
    logic [$clog2(`LANES)-1:0]    mem_lane;
    coeff_t                       mem_wdata, mem_rdata;

    // Adapter to registers
    logic                         reg_we, reg_sel_en;
    logic [$bits(ntt_ctrl_t)-1:0] reg_wdata, reg_rdata;

    ntt_ahb_mem_adapter u_adapter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ahb_req_i     (ahb_req_i),
        .ahb_rsp_o     (ahb_rsp_o),
        .eng_wr_en_i   (eng_req_i.wr_en),     // Snoop for collisions
        .eng_wr_addr_i (eng_req_i.wr_addr),
        .mem_ena_o     (mem_ena),
        .mem_wea_o     (mem_wea),
        .mem_word_o    (mem_word),
        .mem_lane_o    (mem_lane),
        .mem_wdata_o   (mem_wdata),
        .mem_rdata_i   (mem_rdata),
        .reg_we_o      (reg_we),
        .reg_sel_en_o  (reg_sel_en),
        .reg_wdata_o   (reg_wdata),
        .reg_rdata_i   (reg_rdata)
    );

    ntt_ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .we_i       (reg_we),
        .sel_en_i   (reg_sel_en),
        .wdata_i    (reg_wdata),
        .rdata_o    (reg_rdata),
        .ntt_ctrl_o (ntt_ctrl_o),
        .ntt_en_o   (ntt_en_o)
    );

    ntt_coeff_mem u_coeff_mem (
        .clk          (clk),
        .host_ena_i   (mem_ena),
        .host_wea_i   (mem_wea),
        .host_word_i  (mem_word),
        .host_lane_i  (mem_lane),
        .host_wdata_i (mem_wdata),
        .host_rdata_o (mem_rdata),
        .eng_req_i    (eng_req_i),
        .eng_rdata_o  (ntt_rd_data_o)
    );

endmodule

`default_nettype wire

// File: logic/ntt_coeff_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "ntt_mem_cfg.svh"

module ntt_coeff_mem
    import ntt_types_pkg::*;
(
    input  wire                        clk,

    // Host port, one lane per access
    input  wire                        host_ena_i,    // Read strobe
    input  wire                        host_wea_i,    // Write strobe
    input  wire [`WORD_ADDR_W-1:0]     host_word_i,
    input  wire [$clog2(`LANES)-1:0]   host_lane_i,
    input  wire coeff_t                host_wdata_i,
    output coeff_t                     host_rdata_o,

    // Engine port, whole words
    input  wire ntt_port_req_t         eng_req_i,
    output ntt_word_t                  eng_rdata_o
);

    // One polynomial, four coefficients per entry
    ntt_word_t mem_q [`MEM_WORDS];

    // Four lanes must fill the word exactly
    initial begin
        assert ($bits(ntt_word_t) == `WORD_W)
            else $fatal(1, "ntt_word_t is not WORD_W bits");
    end

    // ====================
    // Writes
    // ====================
    always_ff @(posedge clk) begin
        if (host_wea_i) begin
            mem_q[host_word_i][host_lane_i] <= host_wdata_i;   // Other lanes kept
        end
        if (eng_req_i.wr_en) begin
            mem_q[eng_req_i.wr_addr] <= eng_req_i.wr_data;     // Full word
        end
    end

    // ====================
    // Reads
    // ====================
    // Host read, registered lane select
    always_ff @(posedge clk) begin
        if (host_ena_i) begin
            host_rdata_o <= mem_q[host_word_i][host_lane_i];
        end
    end

    // Engine read, data one cycle after rd_en, old data on same-word write
    always_ff @(posedge clk) begin
        if (eng_req_i.rd_en) begin
            eng_rdata_o <= mem_q[eng_req_i.rd_addr];
        end
    end

    // Adapter must hold the host off a word the engine is writing
    a_no_wr_collide: assert property (@(posedge clk)
        (host_wea_i && eng_req_i.wr_en) |-> (host_word_i != eng_req_i.wr_addr));

endmodule

`default_nettype wire

// File: logic/ntt_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_regs
    import ntt_types_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           we_i,
    input  wire                           sel_en_i,   // 1 enable slot, 0 control
    input  wire [$bits(ntt_ctrl_t)-1:0]   wdata_i,
    output logic [$bits(ntt_ctrl_t)-1:0]  rdata_o,    // Control readback
    output ntt_ctrl_t                     ntt_ctrl_o,
    output logic                          ntt_en_o
);

    ntt_ctrl_t ctrl_q;
    logic      en_q;

    // ====================
    // Control register
    // ====================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (we_i && !sel_en_i) begin
            // Field decode, new values visible right after the edge
            ctrl_q.mode          <= mode_t'(wdata_i[2:0]);
            ctrl_q.accumulate    <= wdata_i[3];   // Add into destination
            ctrl_q.sampler_valid <= wdata_i[4];
            ctrl_q.masking_en    <= wdata_i[5];
            ctrl_q.shuffle_en    <= wdata_i[6];
            ctrl_q.zeroize       <= wdata_i[7];   // Clear engine state
            ctrl_q.sampler_mode  <= wdata_i[8];
        end
    end

    // ====================
    // Enable slot
    // ====================
    // Not stored, a write of one becomes a one-cycle pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= we_i & sel_en_i & wdata_i[0];
        end
    end

    assign ntt_ctrl_o = ctrl_q;
    assign ntt_en_o   = en_q;
    assign rdata_o    = ctrl_q;   // Nine field bits as stored

    // Host must not start the engine on consecutive cycles
    a_en_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ntt_en_o |=> !ntt_en_o);

endmodule

`default_nettype wire

// File: logic/ntt_ahb_mem_adapter.sv
`timescale 1ns/1ps
`default_nettype none
`include "ntt_mem_cfg.svh"

module ntt_ahb_mem_adapter
    import ntt_types_pkg::*;
    import ahb_bus_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n_i,

    // Host bus
    input  wire ahb_req_t                ahb_req_i,
    output ahb_rsp_t                     ahb_rsp_o,

    // Engine write snoop for collisions
    input  wire                          eng_wr_en_i,
    input  wire [`WORD_ADDR_W-1:0]       eng_wr_addr_i,

    // Toward coefficient memory
    output logic                         mem_ena_o,     // Lane read strobe
    output logic                         mem_wea_o,     // Lane write strobe
    output logic [`WORD_ADDR_W-1:0]      mem_word_o,
    output logic [$clog2(`LANES)-1:0]    mem_lane_o,
    output coeff_t                       mem_wdata_o,
    input  wire coeff_t                  mem_rdata_i,

    // Toward register block
    output logic                         reg_we_o,
    output logic                         reg_sel_en_o,  // 1 enable slot, 0 control
    output logic [$bits(ntt_ctrl_t)-1:0] reg_wdata_o,
    input  wire [$bits(ntt_ctrl_t)-1:0]  reg_rdata_i
);

    localparam int LANE_W = $clog2(`LANES);
    localparam int CTRL_W = $bits(ntt_ctrl_t);

    // Where a pending read gets its data
    typedef enum logic [1:0] {SRC_MEM, SRC_CTRL, SRC_ZERO} rd_src_e;

    logic                   is_coeff, is_ctrl, is_en, is_err;
    logic                   collide;
    logic                   accept;
    logic                   rd_pend_q;
    rd_src_e                rd_src_q;
    logic [`AHB_DATA_W-1:0] rd_now;
    logic [`AHB_DATA_W-1:0] rdata_q;   // Last returned read data

    // ====================
    // Address decode
    // ====================
    always_comb begin
        is_coeff = (ahb_req_i.addr < `AHB_ADDR_W'(`CTRL_ADDR));
        is_ctrl  = (ahb_req_i.addr == `AHB_ADDR_W'(`CTRL_ADDR));
        is_en    = (ahb_req_i.addr == `AHB_ADDR_W'(`EN_ADDR));
        is_err   = ~(is_coeff | is_ctrl | is_en);   // Anything above EN_ADDR
    end

    // Engine write to the same word wins, host must retry
    assign collide = ahb_req_i.dv & is_coeff & eng_wr_en_i
                   & (ahb_req_i.addr[LANE_W +: `WORD_ADDR_W] == eng_wr_addr_i);

    assign accept = ahb_req_i.dv & ~collide & ~is_err;

    // ====================
    // Request steering
    // ====================
    always_comb begin
        mem_ena_o    = accept & is_coeff & ~ahb_req_i.write;
        mem_wea_o    = accept & is_coeff & ahb_req_i.write;
        mem_word_o   = ahb_req_i.addr[LANE_W +: `WORD_ADDR_W];   // Bits 7:2
        mem_lane_o   = ahb_req_i.addr[LANE_W-1:0];               // Bits 1:0
        mem_wdata_o  = ahb_req_i.wdata[`COEFF_W-1:0];             // Upper bits dropped

        reg_we_o     = accept & ~is_coeff & ahb_req_i.write;
        reg_sel_en_o = is_en;
        reg_wdata_o  = ahb_req_i.wdata[CTRL_W-1:0];
    end

    // Remember source of an accepted read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_pend_q <= 1'b0;
            rd_src_q  <= SRC_ZERO;
            rdata_q   <= '0;
        end else begin
            rd_pend_q <= accept & ~ahb_req_i.write;
            if (accept && !ahb_req_i.write) begin
                rd_src_q <= is_coeff ? SRC_MEM : (is_ctrl ? SRC_CTRL : SRC_ZERO);
            end
            if (rd_pend_q) rdata_q <= rd_now;   // Keep for idle cycles
        end
    end

    // Return mux, everything zero-extended to the bus
    always_comb begin
        case (rd_src_q)
            SRC_MEM:  rd_now = {{(`AHB_DATA_W-`COEFF_W){1'b0}}, mem_rdata_i};
            SRC_CTRL: rd_now = {{(`AHB_DATA_W-CTRL_W){1'b0}}, reg_rdata_i};
            default:  rd_now = '0;   // Enable slot reads as zero
        endcase
    end

    assign ahb_rsp_o.rdata = rd_pend_q ? rd_now : rdata_q;
    assign ahb_rsp_o.hold  = collide;
    assign ahb_rsp_o.err   = ahb_req_i.dv & is_err;

    // Read data moves only on the cycle after an accepted read
    a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        !rd_pend_q |-> $stable(ahb_rsp_o.rdata));

endmodule

`default_nettype wire

// File: logic/ahb_bus_pkg.sv
`default_nettype none
`include "ntt_mem_cfg.svh"

package ahb_bus_pkg;

    // ====================
    // Host transfer, one cycle with dv high
    // ====================
    typedef struct packed {
        logic                   dv;      // Transfer valid
        logic                   write;   // 1 write, 0 read
        logic [`AHB_ADDR_W-1:0] addr;    // Coefficient index or slot
        logic [`AHB_DATA_W-1:0] wdata;   // Only low 24 bits reach memory
    } ahb_req_t;

    // ====================
    // Response
    // ====================
    // hold and err are same-cycle, rdata lags an accepted read by one
    typedef struct packed {
        logic [`AHB_DATA_W-1:0] rdata;
        logic                   hold;    // Retry, nothing performed
        logic                   err;     // Dropped, bad address
    } ahb_rsp_t;

endpackage

`default_nettype wire

// File: logic/ntt_types_pkg.sv
`default_nettype none
`include "ntt_mem_cfg.svh"

package ntt_types_pkg;

    typedef logic [`COEFF_W-1:0] coeff_t;

    // Lane 0 sits in the low bits of the word
    typedef coeff_t [`LANES-1:0] ntt_word_t;

    // Operation select for the engine
    typedef enum logic [2:0] {
        MODE_NTT  = 3'd0,
        MODE_INTT = 3'd1,
        MODE_PWM  = 3'd2,   // Point-wise multiply
        MODE_PWA  = 3'd3,   // Point-wise add
        MODE_PWS  = 3'd4,   // Point-wise subtract
        MODE_IDLE = 3'd7
    } mode_t;

    // Field order matches the control register, mode in bits 2:0
    typedef struct packed {
        logic  sampler_mode;    // Bit 8
        logic  zeroize;         // Bit 7
        logic  shuffle_en;      // Bit 6
        logic  masking_en;      // Bit 5
        logic  sampler_valid;   // Bit 4
        logic  accumulate;      // Bit 3
        mode_t mode;            // Bits 2:0
    } ntt_ctrl_t;

    // Engine side request, whole words only
    typedef struct packed {
        logic                    rd_en;
        logic [`WORD_ADDR_W-1:0] rd_addr;
        logic                    wr_en;
        logic [`WORD_ADDR_W-1:0] wr_addr;
        ntt_word_t               wr_data;
    } ntt_port_req_t;

endpackage

`default_nettype wire

// File: logic/ntt_mem_cfg.svh
`ifndef NTT_MEM_CFG_SVH
`define NTT_MEM_CFG_SVH

// ====================
// Coefficient and word geometry
// ====================
`define COEFF_W      24    // One coefficient
`define LANES        4     // Coefficients per memory word
`define WORD_W       96    // LANES * COEFF_W
`define WORD_ADDR_W  6     // Word index width
`define MEM_WORDS    64    // One polynomial of 256 coeffs

// ====================
// Host bus
// ====================
`define AHB_DATA_W   32
`define AHB_ADDR_W   9
`define CTRL_ADDR    256   // First slot past the coefficients
`define EN_ADDR      257   // Enable slot, last legal address

`endif
